/* fu_cluster.f */
+incdir+verilog
verilog/fu_pkg.sv
verilog/fu_operand_decode.sv
verilog/alu.sv
verilog/mult_stage.sv
verilog/mult.sv
verilog/cdb_arbiter.sv
verilog/fu_cluster.sv
test/fu_cluster_assert.sv
test/fu_cluster_checker.sv
test/fu_cluster_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -f fu_cluster.f --top-module fu_cluster_tb -o fu_cluster_sim

out=$(./obj_dir/fu_cluster_sim +verilator+error+limit+100)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qF '*** PASSED ***'; then
  exit 0
else
  exit 1
fi

/* test/fu_cluster_assert.sv */
module fu_cluster_assert (
  input logic             clock,
  input logic             reset,
  input logic             issue_ready,
  input fu_pkg::fu_func_t issue_func,
  input logic             mult_valid,
  input logic             alu_full,
  input logic             mult_full,
  input fu_pkg::tag_t     alu_buf_tag,
  input fu_pkg::rob_idx_t alu_buf_rob,
  input fu_pkg::tag_t     mult_buf_tag,
  input fu_pkg::rob_idx_t mult_buf_rob,
  input logic             rollback_en,
  input logic             cdb_valid,
  input logic             cdb_ready,
  input fu_pkg::word_t    cdb_value,
  input fu_pkg::tag_t     cdb_tag,
  input fu_pkg::rob_idx_t cdb_rob
);

  import fu_pkg::*;

  // bumped by every failing assertion, read back by the testbench
  int fail_count = 0;

  logic alu_leaving;
  logic mult_leaving;

  // buffer entry handed to the receiver at this edge
  assign alu_leaving = cdb_valid && cdb_ready &&
                       (cdb_tag == alu_buf_tag) && (cdb_rob == alu_buf_rob);
  assign mult_leaving = cdb_valid && cdb_ready &&
                        (cdb_tag == mult_buf_tag) && (cdb_rob == mult_buf_rob);

  // stalled cdb keeps its payload, a squash may still pull it
  a_cdb_stable: assert property (@(posedge clock) disable iff (reset)
    cdb_valid && !cdb_ready && !rollback_en |=>
      cdb_valid && $stable(cdb_value) && $stable(cdb_tag) && $stable(cdb_rob))
  else begin
    $error("cdb payload changed while the receiver was stalling");
    fail_count++;
  end

  // both buffers empty coming out of reset
  a_reset_idle: assert property (@(posedge clock)
    $past(reset) && !reset |-> !cdb_valid)
  else begin
    $error("cdb_valid high in the first cycle after reset");
    fail_count++;
  end

  // alu op only offered when its buffer is empty or leaving now
  a_alu_ready: assert property (@(posedge clock) disable iff (reset)
    issue_ready && (issue_func != MULQ) |-> !alu_full || alu_leaving)
  else begin
    $error("issue_ready for an alu op with a full alu buffer");
    fail_count++;
  end

  // multiply only offered when the last stage is empty or can move on
  a_mult_ready: assert property (@(posedge clock) disable iff (reset)
    issue_ready && (issue_func == MULQ) |-> !mult_valid || !mult_full || mult_leaving)
  else begin
    $error("issue_ready for a multiply with a stalled pipeline");
    fail_count++;
  end

endmodule

bind fu_cluster fu_cluster_assert u_assert (
  .clock        (clock),
  .reset        (reset),
  .issue_ready  (issue_ready),
  .issue_func   (issue_func),
  .mult_valid   (mult_valid),
  .alu_full     (u_arbiter.alu_full),
  .mult_full    (u_arbiter.mult_full),
  .alu_buf_tag  (u_arbiter.alu_tag_q),
  .alu_buf_rob  (u_arbiter.alu_rob_q),
  .mult_buf_tag (u_arbiter.mult_tag_q),
  .mult_buf_rob (u_arbiter.mult_rob_q),
  .rollback_en  (rollback_en),
  .cdb_valid    (cdb_valid),
  .cdb_ready    (cdb_ready),
  .cdb_value    (cdb_value),
  .cdb_tag      (cdb_tag),
  .cdb_rob      (cdb_rob)
);

/* test/fu_cluster_checker.sv */
module fu_cluster_checker (
  input  logic             clock,
  input  logic             reset,
  input  logic             issue_valid,
  input  logic             issue_ready,
  input  fu_pkg::fu_func_t issue_func,
  input  fu_pkg::word_t    issue_t1,
  input  fu_pkg::word_t    issue_t2,
  input  logic             issue_use_imm,
  input  fu_pkg::lit_t     issue_lit,
  input  fu_pkg::tag_t     issue_tag,
  input  fu_pkg::rob_idx_t issue_rob,
  input  logic             rollback_en,
  input  fu_pkg::rob_idx_t rollback_idx,
  input  logic             cdb_valid,
  input  logic             cdb_ready,
  input  fu_pkg::word_t    cdb_value,
  input  fu_pkg::tag_t     cdb_tag,
  input  fu_pkg::rob_idx_t cdb_rob,
  input  logic             final_check,
  output int               value_errors,
  output int               protocol_errors,
  output int               missing_errors,
  output int               pending_count
);

  import fu_pkg::*;

  localparam int NUM_TAGS = 2 ** $bits(tag_t);

  // life of one destination tag
  typedef enum logic [1:0] {IDLE, PENDING, DONE, SQUASHED} slot_state_t;

  slot_state_t slot_state [NUM_TAGS];
  word_t       exp_value  [NUM_TAGS];
  rob_idx_t    exp_rob    [NUM_TAGS];
  logic        final_done;

  // reference result straight from the operation rules
  function automatic word_t expected_result(input fu_func_t func, input word_t a,
                                            input word_t b);
    word_t      r;
    logic [5:0] sh;
    sh = b[5:0];
    case (func)
      ADDQ:    r = a + b;
      SUBQ:    r = a - b;
      AND:     r = a & b;
      BIC:     r = a & ~b;
      BIS:     r = a | b;
      ORNOT:   r = a | ~b;
      XOR:     r = a ^ b;
      EQV:     r = ~(a ^ b);
      SRL:     r = a >> sh;
      SLL:     r = a << sh;
      SRA:     r = $signed(a) >>> sh;
      CMPULT:  r = word_t'(a < b);
      CMPEQ:   r = word_t'(a == b);
      CMPULE:  r = word_t'(a <= b);
      CMPLT:   r = word_t'($signed(a) < $signed(b));
      CMPLE:   r = word_t'($signed(a) <= $signed(b));
      // low word of the full product
      MULQ:    r = a * b;
      default: r = '0;
    endcase
    return r;
  endfunction

  always @(posedge clock) begin
    word_t opb;
    if (reset) begin
      for (int t = 0; t < NUM_TAGS; t++) begin
        slot_state[t] = IDLE;
      end
      value_errors    = 0;
      protocol_errors = 0;
      missing_errors  = 0;
      pending_count   = 0;
      final_done      = 1'b0;
    end else begin
      // result leaving on the cdb
      if (cdb_valid && cdb_ready) begin
        if (slot_state[cdb_tag] == PENDING) begin
          if (cdb_value !== exp_value[cdb_tag] || cdb_rob !== exp_rob[cdb_tag]) begin
            $display("FAILED t=%0t tag %0d: got value %h rob %0d, expected %h rob %0d",
                     $time, cdb_tag, cdb_value, cdb_rob, exp_value[cdb_tag],
                     exp_rob[cdb_tag]);
            value_errors++;
          end
          slot_state[cdb_tag] = DONE;
          pending_count--;
        end else if (slot_state[cdb_tag] == DONE) begin
          $display("tag %0d showed up on the CDB a second time", cdb_tag);
          protocol_errors++;
        end else if (slot_state[cdb_tag] == SQUASHED) begin
          $display("tag %0d was rolled back but still reached the CDB", cdb_tag);
          protocol_errors++;
        end else begin
          $display("CDB carried tag %0d that was never issued", cdb_tag);
          protocol_errors++;
        end
      end
      // squash hits only ops accepted before this edge
      if (rollback_en) begin
        for (int t = 0; t < NUM_TAGS; t++) begin
          if (slot_state[t] == PENDING && exp_rob[t] == rollback_idx) begin
            slot_state[t] = SQUASHED;
            pending_count--;
          end
        end
      end
      // newly accepted op
      if (issue_valid && issue_ready) begin
        opb = issue_use_imm ? word_t'(issue_lit) : issue_t2;
        exp_value[issue_tag]  = expected_result(issue_func, issue_t1, opb);
        exp_rob[issue_tag]    = issue_rob;
        slot_state[issue_tag] = PENDING;
        pending_count++;
      end
      // anything still pending now is lost
      if (final_check && !final_done) begin
        final_done = 1'b1;
        for (int t = 0; t < NUM_TAGS; t++) begin
          if (slot_state[t] == PENDING) begin
            $display("tag %0d (rob %0d) was accepted but its result never reached the CDB",
                     t, exp_rob[t]);
            missing_errors++;
          end
        end
      end
    end
  end

endmodule

/* test/fu_cluster_tb.sv */
module fu_cluster_tb;

  import fu_pkg::*;

  localparam int NUM_ROWS     = 30;
  localparam int RESET_CYCLES = 8;
  // per-row allowance covers back-pressure and pipeline drain
  localparam int WATCHDOG_CYCLES = NUM_ROWS * 30;
  // results still owed after this many idle-issue cycles are lost
  localparam int DRAIN_CYCLES = 100;

  logic     clock, reset;
  logic     issue_valid, issue_ready, issue_use_imm;
  fu_func_t issue_func;
  word_t    issue_t1, issue_t2;
  lit_t     issue_lit;
  tag_t     issue_tag;
  rob_idx_t issue_rob;
  logic     rollback_en;
  rob_idx_t rollback_idx;
  logic     cdb_valid, cdb_ready;
  word_t    cdb_value;
  tag_t     cdb_tag;
  rob_idx_t cdb_rob;

  logic final_check, issue_fire;
  int   value_errors, protocol_errors, missing_errors, pending_count;
  int   tb_errors, assert_errors, row_count;
  int   seed = 98;

  // stimulus table, row index doubles as tag and rob index
  fu_func_t row_func     [NUM_ROWS];
  word_t    row_t1       [NUM_ROWS];
  word_t    row_t2       [NUM_ROWS];
  logic     row_imm      [NUM_ROWS];
  lit_t     row_lit      [NUM_ROWS];
  logic     row_rollback [NUM_ROWS];

  fu_cluster DUT (.*);

  fu_cluster_checker u_checker (.*);

  task automatic add_row(input fu_func_t func, input word_t t1, input word_t t2,
                         input logic use_imm, input lit_t lit, input logic rollback);
    row_func[row_count]     = func;
    row_t1[row_count]       = t1;
    row_t2[row_count]       = t2;
    row_imm[row_count]      = use_imm;
    row_lit[row_count]      = lit;
    row_rollback[row_count] = rollback;
    row_count++;
  endtask

  task automatic build_table();
    // register operand alu ops
    add_row(ADDQ,   64'd5, 64'd7, 1'b0, 8'h00, 1'b0);
    add_row(SUBQ,   64'd3, 64'd10, 1'b0, 8'h00, 1'b0);
    add_row(AND,    64'hff00_ff00_ff00_ff00, 64'h0f0f_0f0f_0f0f_0f0f, 1'b0, 8'h00, 1'b0);
    add_row(BIC,    64'hff00_ff00_ff00_ff00, 64'h0f0f_0f0f_0f0f_0f0f, 1'b0, 8'h00, 1'b0);
    add_row(BIS,    64'h1234_0000_0000_5678, 64'h0000_abcd_ef00_0000, 1'b0, 8'h00, 1'b0);
    add_row(ORNOT,  64'h0000_0000_0000_00f0, 64'hffff_ffff_0000_0000, 1'b0, 8'h00, 1'b0);
    add_row(XOR,    64'haaaa_5555_aaaa_5555, 64'hffff_0000_ffff_0000, 1'b0, 8'h00, 1'b0);
    add_row(EQV,    64'haaaa_5555_aaaa_5555, 64'hffff_0000_ffff_0000, 1'b0, 8'h00, 1'b0);
    // shifts at the far end of the range
    add_row(SRL,    64'h8000_0000_0000_0000, 64'd63, 1'b0, 8'h00, 1'b0);
    add_row(SLL,    64'd1, 64'd63, 1'b0, 8'h00, 1'b0);
    add_row(SRA,    64'h8000_0000_0000_0010, 64'd4, 1'b0, 8'h00, 1'b0);
    add_row(SRA,    64'hffff_ffff_ffff_ff00, 64'hffc0_0000_0000_003f, 1'b0, 8'h00, 1'b0);
    // signed against unsigned corners
    add_row(CMPULT, 64'd1, 64'hffff_ffff_ffff_ffff, 1'b0, 8'h00, 1'b0);
    add_row(CMPLT,  64'd1, 64'hffff_ffff_ffff_ffff, 1'b0, 8'h00, 1'b0);
    add_row(CMPEQ,  64'hdead_beef_0000_0001, 64'hdead_beef_0000_0001, 1'b0, 8'h00, 1'b0);
    add_row(CMPULE, 64'h8000_0000_0000_0000, 64'h8000_0000_0000_0000, 1'b0, 8'h00, 1'b0);
    add_row(CMPLE,  64'h8000_0000_0000_0000, 64'h7fff_ffff_ffff_ffff, 1'b0, 8'h00, 1'b0);
    // back to back multiplies, one squashed mid pipe
    add_row(MULQ,   64'hffff_ffff_ffff_ffff, 64'd2, 1'b0, 8'h00, 1'b0);
    add_row(MULQ,   64'h0123_4567_89ab_cdef, 64'hfedc_ba98_7654_3210, 1'b0, 8'h00, 1'b0);
    add_row(MULQ,   64'h8000_0000_0000_0001, 64'h8000_0000_0000_0001, 1'b0, 8'h00, 1'b1);
    add_row(MULQ,   64'hdead_beef_cafe_babe, 64'h0000_0000_1234_5678, 1'b0, 8'h00, 1'b0);
    // literal path, t2 is junk and must be ignored
    add_row(ADDQ,   64'd100, 64'hffff_0000_ffff_0000, 1'b1, 8'hff, 1'b0);
    add_row(SRA,    64'hf000_0000_0000_0000, 64'd1, 1'b1, 8'h3f, 1'b0);
    add_row(MULQ,   64'h7fff_ffff_ffff_ffff, 64'h7fff_ffff_ffff_ffff, 1'b0, 8'h00, 1'b0);
    add_row(CMPULT, 64'h0000_0000_0000_0080, 64'd0, 1'b1, 8'h81, 1'b0);
    add_row(MULQ,   64'h0000_0000_ffff_ffff, 64'd3, 1'b1, 8'h10, 1'b0);
    // squashed multiply between two alu neighbours
    add_row(XOR,    64'h0f0f_0f0f_0f0f_0f0f, 64'hffff_ffff_ffff_ffff, 1'b0, 8'h00, 1'b0);
    add_row(MULQ,   64'h1111_1111_1111_1111, 64'h0000_0000_0000_000f, 1'b0, 8'h00, 1'b1);
    add_row(SUBQ,   64'd0, 64'd1, 1'b0, 8'h00, 1'b0);
    add_row(CMPLE,  64'hffff_ffff_ffff_ffff, 64'd0, 1'b0, 8'h00, 1'b0);
  endtask

  task automatic drive_row(input int r);
    issue_valid   = 1'b1;
    issue_func    = row_func[r];
    issue_t1      = row_t1[r];
    issue_t2      = row_t2[r];
    issue_use_imm = row_imm[r];
    issue_lit     = row_lit[r];
    issue_tag     = tag_t'(r);
    issue_rob     = rob_idx_t'(r);
  endtask

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  // cdb receiver ready about three cycles in four
  initial begin
    cdb_ready = 1'b0;
    forever begin
      @(negedge clock);
      cdb_ready = ($random(seed) % 4) != 0;
    end
  end

  // handshake seen at the last rising edge
  always_ff @(posedge clock) begin
    if (reset) begin
      issue_fire <= 1'b0;
    end else begin
      issue_fire <= issue_valid && issue_ready;
    end
  end

  initial begin
    repeat (RESET_CYCLES + WATCHDOG_CYCLES) @(posedge clock);
    $display("timeout: not all rows finished within %0d cycles", WATCHDOG_CYCLES);
    $display("*** FAILED ***");
    $finish;
  end

  initial begin
    int r;
    int drain_wait;
    reset         = 1'b1;
    issue_valid   = 1'b0;
    issue_func    = ADDQ;
    issue_t1      = '0;
    issue_t2      = '0;
    issue_use_imm = 1'b0;
    issue_lit     = '0;
    issue_tag     = '0;
    issue_rob     = '0;
    rollback_en   = 1'b0;
    rollback_idx  = '0;
    final_check   = 1'b0;
    tb_errors     = 0;
    row_count     = 0;
    build_table();

    repeat (RESET_CYCLES) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    @(negedge clock);
    // idle cluster right after reset
    if (cdb_valid || !issue_ready) begin
      $display("cluster not idle after reset: cdb_valid=%b issue_ready=%b",
               cdb_valid, issue_ready);
      tb_errors++;
    end

    for (r = 0; r < NUM_ROWS; r++) begin
      drive_row(r);
      @(negedge clock);
      // rollback lasts exactly one edge
      rollback_en = 1'b0;
      while (!issue_fire) begin
        @(negedge clock);
      end
      // squash the op just accepted at the next edge
      if (row_rollback[r]) begin
        rollback_en  = 1'b1;
        rollback_idx = rob_idx_t'(r);
      end
    end
    issue_valid = 1'b0;
    @(negedge clock);
    rollback_en = 1'b0;

    // drain every surviving result, anything left after that is missing
    drain_wait = 0;
    while ((pending_count != 0 || cdb_valid) && drain_wait < DRAIN_CYCLES) begin
      @(negedge clock);
      drain_wait++;
    end
    final_check = 1'b1;
    @(negedge clock);
    final_check = 1'b0;

    assert_errors = DUT.u_assert.fail_count;
    $display("errors: value %0d, protocol %0d, missing %0d, testbench %0d, assertion %0d",
             value_errors, protocol_errors, missing_errors, tb_errors, assert_errors);
    if (value_errors + protocol_errors + missing_errors + tb_errors + assert_errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

/* verilog/alu.sv */
module alu (
  input  fu_pkg::fu_func_t func,
  input  fu_pkg::word_t    opa,
  input  fu_pkg::word_t    opb,
  output fu_pkg::word_t    result
);

  import fu_pkg::*;

  logic [5:0] shamt;
  logic [6:0] fill_shamt;
  word_t      sign_fill;

  // two's complement less-than on raw vectors
  function automatic logic signed_lt(input word_t a, input word_t b);
    logic lt;
    // same sign: unsigned order is already right
    if (a[$bits(word_t)-1] == b[$bits(word_t)-1]) begin
      lt = (a < b);
    end else begin
      // signs differ, the negative one is smaller
      lt = a[$bits(word_t)-1];
    end
    return lt;
  endfunction

  // shifts only look at the low 6 bits of b
  assign shamt = opb[5:0];

  // sra = logical shift plus sign bits filled in from the top
  // fill shift of 64 drops all fill bits when shamt is zero
  assign fill_shamt = 7'd64 - {1'b0, shamt};
  assign sign_fill  = {$bits(word_t){opa[$bits(word_t)-1]}} << fill_shamt;

  always_comb begin
    case (func)
      ADDQ:    result = opa + opb;
      SUBQ:    result = opa - opb;
      AND:     result = opa & opb;
      BIC:     result = opa & ~opb;
      BIS:     result = opa | opb;
      ORNOT:   result = opa | ~opb;
      XOR:     result = opa ^ opb;
      EQV:     result = opa ^ ~opb;
      SRL:     result = opa >> shamt;
      SLL:     result = opa << shamt;
      SRA:     result = (opa >> shamt) | sign_fill;
      // compares give 0 or 1 in bit 0
      CMPULT:  result = word_t'(opa < opb);
      CMPEQ:   result = word_t'(opa == opb);
      CMPULE:  result = word_t'(opa <= opb);
      CMPLT:   result = word_t'(signed_lt(opa, opb));
      CMPLE:   result = word_t'(signed_lt(opa, opb) || (opa == opb));
      // MULQ never reaches this unit
      default: result = '0;
    endcase
  end

endmodule

/* verilog/cdb_arbiter.sv */
module cdb_arbiter (
  input  logic             clock,
  input  logic             reset,
  input  logic             alu_load,
  input  fu_pkg::word_t    alu_result,
  input  fu_pkg::tag_t     alu_tag,
  input  fu_pkg::rob_idx_t alu_rob,
  input  logic             mult_valid,
  input  fu_pkg::word_t    mult_value,
  input  fu_pkg::tag_t     mult_tag,
  input  fu_pkg::rob_idx_t mult_rob,
  input  logic             rollback_en,
  input  fu_pkg::rob_idx_t rollback_idx,
  input  logic             cdb_ready,
  output logic             alu_slot_free,
  output logic             mult_take,
  output logic             cdb_valid,
  output fu_pkg::word_t    cdb_value,
  output fu_pkg::tag_t     cdb_tag,
  output fu_pkg::rob_idx_t cdb_rob
);

  import fu_pkg::*;

  logic     alu_full, mult_full, alu_sticky;
  word_t    alu_val_q, mult_val_q;
  tag_t     alu_tag_q, mult_tag_q;
  rob_idx_t alu_rob_q, mult_rob_q;
  logic     sel_mult, alu_drain, mult_drain, alu_kill, mult_kill;

  // mult first, unless an alu result is already stuck on the bus
  assign sel_mult = mult_full && !(alu_sticky && alu_full);

  assign cdb_valid = alu_full || mult_full;
  assign cdb_value = sel_mult ? mult_val_q : alu_val_q;
  assign cdb_tag   = sel_mult ? mult_tag_q : alu_tag_q;
  assign cdb_rob   = sel_mult ? mult_rob_q : alu_rob_q;

  assign mult_drain = mult_full && sel_mult && cdb_ready;
  assign alu_drain  = alu_full && !sel_mult && cdb_ready;
  assign mult_kill  = rollback_en && (mult_rob_q == rollback_idx);
  assign alu_kill   = rollback_en && (alu_rob_q == rollback_idx);

  // free now or emptied at this edge
  assign alu_slot_free = !alu_full || alu_drain;
  assign mult_take     = mult_valid && (!mult_full || mult_drain);

  always_ff @(posedge clock) begin
    if (reset) begin
      alu_full   <= 1'b0;
      mult_full  <= 1'b0;
      alu_sticky <= 1'b0;
    end else begin
      // a load on the same edge wins over any clear
      alu_full   <= alu_load || (alu_full && !alu_drain && !alu_kill);
      mult_full  <= mult_take || (mult_full && !mult_drain && !mult_kill);
      // alu result shown but not taken keeps the bus next cycle
      alu_sticky <= cdb_valid && !sel_mult && !cdb_ready;
    end
  end

  // result payloads
  always_ff @(posedge clock) begin
    if (alu_load) begin
      alu_val_q <= alu_result;
      alu_tag_q <= alu_tag;
      alu_rob_q <= alu_rob;
    end
    if (mult_take) begin
      mult_val_q <= mult_value;
      mult_tag_q <= mult_tag;
      mult_rob_q <= mult_rob;
    end
  end

endmodule

/* verilog/fu_cluster.sv */
module fu_cluster (
  input  logic             clock,
  input  logic             reset,
  input  logic             issue_valid,
  input  fu_pkg::fu_func_t issue_func,
  input  fu_pkg::word_t    issue_t1,
  input  fu_pkg::word_t    issue_t2,
  input  logic             issue_use_imm,
  input  fu_pkg::lit_t     issue_lit,
  input  fu_pkg::tag_t     issue_tag,
  input  fu_pkg::rob_idx_t issue_rob,
  output logic             issue_ready,
  input  logic             rollback_en,
  input  fu_pkg::rob_idx_t rollback_idx,
  output logic             cdb_valid,
  output fu_pkg::word_t    cdb_value,
  output fu_pkg::tag_t     cdb_tag,
  output fu_pkg::rob_idx_t cdb_rob,
  input  logic             cdb_ready
);

  import fu_pkg::*;

  // decode to units
  word_t    opb;
  logic     alu_load, mult_start, alu_slot_free, mult_advance;
  // units to arbiter
  word_t    alu_result, mult_value;
  logic     mult_valid, mult_take;
  tag_t     mult_tag;
  rob_idx_t mult_rob;

  fu_operand_decode u_decode (
    .issue_valid   (issue_valid),
    .issue_func    (issue_func),
    .issue_t2      (issue_t2),
    .issue_use_imm (issue_use_imm),
    .issue_lit     (issue_lit),
    .alu_slot_free (alu_slot_free),
    .mult_advance  (mult_advance),
    .issue_ready   (issue_ready),
    .opb           (opb),
    .alu_load      (alu_load),
    .mult_start    (mult_start)
  );

  alu u_alu (
    .func   (issue_func),
    .opa    (issue_t1),
    .opb    (opb),
    .result (alu_result)
  );

  mult u_mult (
    .clock        (clock),
    .reset        (reset),
    .start        (mult_start),
    .opa          (issue_t1),
    .opb          (opb),
    .tag          (issue_tag),
    .rob          (issue_rob),
    .rollback_en  (rollback_en),
    .rollback_idx (rollback_idx),
    .take         (mult_take),
    .advance      (mult_advance),
    .done_valid   (mult_valid),
    .done_value   (mult_value),
    .done_tag     (mult_tag),
    .done_rob     (mult_rob)
  );

  cdb_arbiter u_arbiter (
    .clock         (clock),
    .reset         (reset),
    .alu_load      (alu_load),
    .alu_result    (alu_result),
    .alu_tag       (issue_tag),
    .alu_rob       (issue_rob),
    .mult_valid    (mult_valid),
    .mult_value    (mult_value),
    .mult_tag      (mult_tag),
    .mult_rob      (mult_rob),
    .rollback_en   (rollback_en),
    .rollback_idx  (rollback_idx),
    .cdb_ready     (cdb_ready),
    .alu_slot_free (alu_slot_free),
    .mult_take     (mult_take),
    .cdb_valid     (cdb_valid),
    .cdb_value     (cdb_value),
    .cdb_tag       (cdb_tag),
    .cdb_rob       (cdb_rob)
  );

endmodule

/* verilog/fu_operand_decode.sv */
module fu_operand_decode (
  input  logic             issue_valid,
  input  fu_pkg::fu_func_t issue_func,
  input  fu_pkg::word_t    issue_t2,
  input  logic             issue_use_imm,
  input  fu_pkg::lit_t     issue_lit,
  input  logic             alu_slot_free,
  input  logic             mult_advance,
  output logic             issue_ready,
  output fu_pkg::word_t    opb,
  output logic             alu_load,
  output logic             mult_start
);

  import fu_pkg::*;

  logic is_mult;
  logic accept;

  // operand b: register value or zero-extended literal
  always_comb begin
    if (issue_use_imm) begin
      opb = word_t'(issue_lit);
    end else begin
      opb = issue_t2;
    end
  end

  // only MULQ goes to the multiplier, everything else is single cycle
  assign is_mult = (issue_func == MULQ);

  // ready follows the unit the op needs
  // alu side already accounts for a same-cycle drain
  assign issue_ready = is_mult ? mult_advance : alu_slot_free;

  // handshake completes this edge
  assign accept = issue_valid && issue_ready;

  // exactly one of these per accepted op
  assign alu_load   = accept && !is_mult;
  assign mult_start = accept && is_mult;

endmodule

/* verilog/fu_pkg.sv */
`include "fu_settings.svh"

package fu_pkg;

  // one data value on the datapath
  typedef logic [`FU_WORD_BITS-1:0] word_t;

  // rob entry index
  typedef logic [$clog2(`FU_NUM_ROB)-1:0] rob_idx_t;

  // physical destination register
  typedef logic [$clog2(`FU_NUM_PR)-1:0] tag_t;

  // 8-bit literal, zero extended when used
  typedef logic [7:0] lit_t;

  // integer operations
  typedef enum logic [4:0] {
    ADDQ,
    SUBQ,
    AND,
    BIC,
    BIS,
    ORNOT,
    XOR,
    EQV,
    SRL,
    SLL,
    SRA,
    CMPULT,
    CMPEQ,
    CMPULE,
    CMPLT,
    CMPLE,
    MULQ
  } fu_func_t;

endpackage

/* verilog/fu_settings.svh */
`ifndef FU_SETTINGS_SVH
`define FU_SETTINGS_SVH

// datapath width in bits
`define FU_WORD_BITS 64

// reorder buffer entries
`define FU_NUM_ROB 16

// physical registers, sets the tag width
`define FU_NUM_PR 32

// multiplier pipeline depth, must divide the word width
`define FU_NUM_MULT_STAGE 4

`endif

/* verilog/mult.sv */
`include "fu_settings.svh"

module mult (
  input  logic             clock,
  input  logic             reset,
  input  logic             start,
  input  fu_pkg::word_t    opa,
  input  fu_pkg::word_t    opb,
  input  fu_pkg::tag_t     tag,
  input  fu_pkg::rob_idx_t rob,
  input  logic             rollback_en,
  input  fu_pkg::rob_idx_t rollback_idx,
  input  logic             take,
  output logic             advance,
  output logic             done_valid,
  output fu_pkg::word_t    done_value,
  output fu_pkg::tag_t     done_tag,
  output fu_pkg::rob_idx_t done_rob
);

  import fu_pkg::*;

  localparam int N = `FU_NUM_MULT_STAGE;

  // chain index 0 is the issue side, index N is the last stage output
  logic     valid_c   [0:N];
  word_t    product_c [0:N];
  word_t    mplier_c  [0:N];
  word_t    mcand_c   [0:N];
  tag_t     tag_c     [0:N];
  rob_idx_t rob_c     [0:N];

  // stage 0 starts from a zero partial sum
  assign valid_c[0]   = start;
  assign product_c[0] = '0;
  assign mplier_c[0]  = opa;
  assign mcand_c[0]   = opb;
  assign tag_c[0]     = tag;
  assign rob_c[0]     = rob;

  // whole pipe stalls if the finished op cannot leave
  assign advance = !(valid_c[N] && !take);

  for (genvar s = 0; s < N; s++) begin : g_stage
    mult_stage u_stage (
      .clock        (clock),
      .reset        (reset),
      .advance      (advance),
      .rollback_en  (rollback_en),
      .rollback_idx (rollback_idx),
      .valid_in     (valid_c[s]),
      .product_in   (product_c[s]),
      .mplier_in    (mplier_c[s]),
      .mcand_in     (mcand_c[s]),
      .tag_in       (tag_c[s]),
      .rob_in       (rob_c[s]),
      .valid_out    (valid_c[s+1]),
      .product_out  (product_c[s+1]),
      .mplier_out   (mplier_c[s+1]),
      .mcand_out    (mcand_c[s+1]),
      .tag_out      (tag_c[s+1]),
      .rob_out      (rob_c[s+1])
    );
  end

  // low word of the product after the last slice
  assign done_valid = valid_c[N];
  assign done_value = product_c[N];
  assign done_tag   = tag_c[N];
  assign done_rob   = rob_c[N];

endmodule

/* verilog/mult_stage.sv */
`include "fu_settings.svh"

module mult_stage (
  input  logic               clock,
  input  logic               reset,
  input  logic               advance,
  input  logic               rollback_en,
  input  fu_pkg::rob_idx_t   rollback_idx,
  input  logic               valid_in,
  input  fu_pkg::word_t      product_in,
  input  fu_pkg::word_t      mplier_in,
  input  fu_pkg::word_t      mcand_in,
  input  fu_pkg::tag_t       tag_in,
  input  fu_pkg::rob_idx_t   rob_in,
  output logic               valid_out,
  output fu_pkg::word_t      product_out,
  output fu_pkg::word_t      mplier_out,
  output fu_pkg::word_t      mcand_out,
  output fu_pkg::tag_t       tag_out,
  output fu_pkg::rob_idx_t   rob_out
);

  import fu_pkg::*;

  // multiplier bits handled per stage
  localparam int SLICE = `FU_WORD_BITS / `FU_NUM_MULT_STAGE;

  logic  valid_q;
  logic  kill;
  word_t partial_product;

  // slice of the multiplier times the already shifted multiplicand
  assign partial_product = word_t'(mplier_in[SLICE-1:0]) * mcand_in;

  // held op is squashed when its rob index matches
  assign kill = rollback_en && (rob_out == rollback_idx);

  // a squashed op is invisible to the next stage and the arbiter
  assign valid_out = valid_q && !kill;

  always_ff @(posedge clock) begin
    if (reset) begin
      valid_q <= 1'b0;
    end else if (advance) begin
      valid_q <= valid_in;
    end else begin
      // stalled: keep the op unless rolled back
      valid_q <= valid_out;
    end
  end

  // payload, no reset needed
  always_ff @(posedge clock) begin
    if (advance) begin
      product_out <= product_in + partial_product;
      mplier_out  <= {{SLICE{1'b0}}, mplier_in[`FU_WORD_BITS-1:SLICE]};
      mcand_out   <= {mcand_in[`FU_WORD_BITS-1-SLICE:0], {SLICE{1'b0}}};
      tag_out     <= tag_in;
      rob_out     <= rob_in;
    end
  end

endmodule
